// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps -f multicore_bus.f \
		--top-module tb_multicore_wrapper -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_multicore_wrapper)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== hdl/axi_lite_bridge.sv ====
`timescale 1ns/10ps

module axi_lite_bridge (
    input logic CLK,
    input logic rst_n,
    generic_bus_if.mem gen_bus_if,
    output bus_types_pkg::addr_t awaddr,
    output logic awvalid,
    input logic awready,
    output bus_types_pkg::word_t wdata_axi,
    output bus_types_pkg::strobe_t wstrb,
    output logic wvalid,
    input logic wready,
    input bus_types_pkg::axi_resp_t bresp,
    input logic bvalid,
    output logic bready,
    output bus_types_pkg::addr_t araddr,
    output logic arvalid,
    input logic arready,
    input bus_types_pkg::word_t rdata_axi,
    input bus_types_pkg::axi_resp_t rresp,
    input logic rvalid,
    output logic rready
);

    typedef enum logic [2:0] {
        BT_IDLE,
        BT_WRITE_ADDR_DATA,
        BT_WRITE_RESP,
        BT_READ_ADDR,
        BT_READ_DATA,
        BT_DONE
    } bt_state_t;

    bt_state_t state;
    logic aw_done;
    logic w_done;
    logic aw_fire;
    logic w_fire;

    bus_types_pkg::addr_t addr_q;
    bus_types_pkg::word_t wdata_q;
    bus_types_pkg::strobe_t strb_q;
    bus_types_pkg::word_t rdata_q;

    assign awvalid = (state == BT_WRITE_ADDR_DATA) && !aw_done;
    assign wvalid = (state == BT_WRITE_ADDR_DATA) && !w_done;
    assign bready = (state == BT_WRITE_RESP);
    assign arvalid = (state == BT_READ_ADDR);
    assign rready = (state == BT_READ_DATA);

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;

    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign wdata_axi = wdata_q;
    assign wstrb = strb_q;

    // completion is a single cycle of busy low.
    assign gen_bus_if.busy = (state != BT_DONE);
    assign gen_bus_if.rdata = rdata_q;

    // payload is captured once so it holds through any back-pressure.
    always_ff @(posedge CLK) begin
        if (state == BT_IDLE && (gen_bus_if.ren || gen_bus_if.wen)) begin
            addr_q <= gen_bus_if.addr;
            wdata_q <= gen_bus_if.wdata;
            strb_q <= gen_bus_if.byte_en;
        end
        if (state == BT_READ_DATA && rvalid) begin
            rdata_q <= rdata_axi;
        end
    end

    // bresp and rresp are not inspected; an error finishes like okay.
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= BT_IDLE;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                BT_IDLE: begin
                    aw_done <= 1'b0;
                    w_done <= 1'b0;
                    if (gen_bus_if.wen) begin
                        state <= BT_WRITE_ADDR_DATA;
                    end else if (gen_bus_if.ren) begin
                        state <= BT_READ_ADDR;
                    end
                end
                BT_WRITE_ADDR_DATA: begin
                    // aw and w may be accepted in either order.
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= BT_WRITE_RESP;
                    end
                end
                BT_WRITE_RESP: begin
                    if (bvalid) begin
                        state <= BT_DONE;
                    end
                end
                BT_READ_ADDR: begin
                    if (arready) begin
                        state <= BT_READ_DATA;
                    end
                end
                BT_READ_DATA: begin
                    if (rvalid) begin
                        state <= BT_DONE;
                    end
                end
                default: begin
                    state <= BT_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/bus_types_pkg.sv ====
package bus_types_pkg;

    // widths of the shared memory bus.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STROBE_W = DATA_W / 8;
    localparam int RESP_W = 2;

    // byte address.
    typedef logic [ADDR_W-1:0] addr_t;

    // one data word.
    typedef logic [DATA_W-1:0] word_t;

    // one enable bit per byte lane.
    typedef logic [STROBE_W-1:0] strobe_t;

    // axi response code as seen on the b and r channels.
    typedef logic [RESP_W-1:0] axi_resp_t;

endpackage

// ==== hdl/front_side_bus_if.sv ====
`timescale 1ns/10ps

// bus from one requester into the memory controller.
interface front_side_bus_if;
    bus_types_pkg::addr_t addr;
    bus_types_pkg::word_t wdata;
    bus_types_pkg::word_t rdata;
    bus_types_pkg::strobe_t byte_en;
    logic ren;
    logic wen;
    logic busy;

    modport requester (
        output addr,
        output wdata,
        output byte_en,
        output ren,
        output wen,
        input rdata,
        input busy
    );

    modport controller (
        input addr,
        input wdata,
        input byte_en,
        input ren,
        input wen,
        output rdata,
        output busy
    );
endinterface

// ==== hdl/generic_bus_if.sv ====
`timescale 1ns/10ps

// single master memory bus between the controller and the translator.
interface generic_bus_if;
    bus_types_pkg::addr_t addr;
    bus_types_pkg::word_t wdata;
    bus_types_pkg::word_t rdata;
    bus_types_pkg::strobe_t byte_en;
    logic ren;
    logic wen;
    logic busy;

    modport cpu (
        output addr,
        output wdata,
        output byte_en,
        output ren,
        output wen,
        input rdata,
        input busy
    );

    modport mem (
        input addr,
        input wdata,
        input byte_en,
        input ren,
        input wen,
        output rdata,
        output busy
    );
endinterface

// ==== hdl/memory_controller.sv ====
`timescale 1ns/10ps

module memory_controller (
    input logic CLK,
    input logic rst_n,
    front_side_bus_if.controller front_side [multicore_cfg_pkg::NUM_REQUESTERS-1:0],
    generic_bus_if.cpu out_gen_bus_if
);

    multicore_cfg_pkg::arb_state_t state;
    // holds the current grant while busy and the previous one while idle.
    multicore_cfg_pkg::req_idx_t last_grant;
    multicore_cfg_pkg::req_idx_t pick_idx;
    logic pick_valid;
    logic granted_done;

    bus_types_pkg::addr_t req_addr [multicore_cfg_pkg::NUM_REQUESTERS-1:0];
    bus_types_pkg::word_t req_wdata [multicore_cfg_pkg::NUM_REQUESTERS-1:0];
    bus_types_pkg::strobe_t req_byte_en [multicore_cfg_pkg::NUM_REQUESTERS-1:0];
    logic [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_ren;
    logic [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_wen;
    logic [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_active;

    // the granted access finishes in the cycle the generic bus drops busy.
    assign granted_done = (state == multicore_cfg_pkg::ARB_BUSY) && !out_gen_bus_if.busy;

    for (genvar i = 0; i < multicore_cfg_pkg::NUM_REQUESTERS; i++) begin : g_front_side
        assign req_addr[i] = front_side[i].addr;
        assign req_wdata[i] = front_side[i].wdata;
        assign req_byte_en[i] = front_side[i].byte_en;
        assign req_ren[i] = front_side[i].ren;
        assign req_wen[i] = front_side[i].wen;
        assign req_active[i] = front_side[i].ren | front_side[i].wen;

        assign front_side[i].rdata = out_gen_bus_if.rdata;
        // only the grantee ever sees busy low.
        assign front_side[i].busy =
            !(granted_done && (last_grant == multicore_cfg_pkg::req_idx_t'(i)));
    end

    // search starts just above the last grant and wraps around.
    always_comb begin
        multicore_cfg_pkg::req_idx_t cand;
        pick_valid = 1'b0;
        pick_idx = last_grant;
        for (int k = 1; k <= multicore_cfg_pkg::NUM_REQUESTERS; k++) begin
            cand = multicore_cfg_pkg::req_idx_t'(
                (int'(last_grant) + k) % multicore_cfg_pkg::NUM_REQUESTERS);
            if (!pick_valid && req_active[cand]) begin
                pick_valid = 1'b1;
                pick_idx = cand;
            end
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= multicore_cfg_pkg::ARB_IDLE;
            // requester 0 wins the first round.
            last_grant <= multicore_cfg_pkg::req_idx_t'(multicore_cfg_pkg::NUM_REQUESTERS - 1);
        end else begin
            case (state)
                multicore_cfg_pkg::ARB_IDLE: begin
                    if (pick_valid) begin
                        state <= multicore_cfg_pkg::ARB_BUSY;
                        last_grant <= pick_idx;
                    end
                end
                multicore_cfg_pkg::ARB_BUSY: begin
                    if (!out_gen_bus_if.busy) begin
                        state <= multicore_cfg_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= multicore_cfg_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // forward the grantee's request, commands only while an access is open.
    assign out_gen_bus_if.addr = req_addr[last_grant];
    assign out_gen_bus_if.wdata = req_wdata[last_grant];
    assign out_gen_bus_if.byte_en = req_byte_en[last_grant];
    assign out_gen_bus_if.ren = (state == multicore_cfg_pkg::ARB_BUSY) && req_ren[last_grant];
    assign out_gen_bus_if.wen = (state == multicore_cfg_pkg::ARB_BUSY) && req_wen[last_grant];

endmodule

// ==== hdl/multicore_cfg_pkg.sv ====
package multicore_cfg_pkg;

    localparam int NUM_HARTS = 2;

    // each hart has a fetch port (even index) and a data port (odd index).
    localparam int NUM_REQUESTERS = NUM_HARTS * 2;
    localparam int REQ_IDX_W = $clog2(NUM_REQUESTERS);

    typedef logic [REQ_IDX_W-1:0] req_idx_t;

    // arbiter is either free to grant or waiting on one access.
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

// ==== hdl/multicore_wrapper.sv ====
`timescale 1ns/10ps

module multicore_wrapper (
    input logic CLK,
    input logic rst_n,
    input bus_types_pkg::addr_t [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_addr,
    input bus_types_pkg::word_t [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_wdata,
    input bus_types_pkg::strobe_t [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_byte_en,
    input logic [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_ren,
    input logic [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_wen,
    output bus_types_pkg::word_t [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_rdata,
    output logic [multicore_cfg_pkg::NUM_REQUESTERS-1:0] req_busy,
    output bus_types_pkg::addr_t awaddr,
    output logic awvalid,
    input logic awready,
    output bus_types_pkg::word_t wdata_axi,
    output bus_types_pkg::strobe_t wstrb,
    output logic wvalid,
    input logic wready,
    input bus_types_pkg::axi_resp_t bresp,
    input logic bvalid,
    output logic bready,
    output bus_types_pkg::addr_t araddr,
    output logic arvalid,
    input logic arready,
    input bus_types_pkg::word_t rdata_axi,
    input bus_types_pkg::axi_resp_t rresp,
    input logic rvalid,
    output logic rready
);

    // requester 2h is the fetch port of hart h, 2h+1 its data port.
    front_side_bus_if front_side_bus [multicore_cfg_pkg::NUM_REQUESTERS-1:0] ();
    generic_bus_if gen_bus ();

    for (genvar i = 0; i < multicore_cfg_pkg::NUM_REQUESTERS; i++) begin : g_requester
        assign front_side_bus[i].addr = req_addr[i];
        assign front_side_bus[i].wdata = req_wdata[i];
        assign front_side_bus[i].byte_en = req_byte_en[i];
        assign front_side_bus[i].ren = req_ren[i];
        assign front_side_bus[i].wen = req_wen[i];
        assign req_rdata[i] = front_side_bus[i].rdata;
        assign req_busy[i] = front_side_bus[i].busy;
    end

    memory_controller mc (
        .CLK(CLK),
        .rst_n(rst_n),
        .front_side(front_side_bus),
        .out_gen_bus_if(gen_bus)
    );

    axi_lite_bridge bt (
        .CLK(CLK),
        .rst_n(rst_n),
        .gen_bus_if(gen_bus),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata_axi(wdata_axi),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata_axi(rdata_axi),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready)
    );

endmodule

// ==== multicore_bus.f ====
hdl/bus_types_pkg.sv
hdl/multicore_cfg_pkg.sv
hdl/generic_bus_if.sv
hdl/front_side_bus_if.sv
hdl/memory_controller.sv
hdl/axi_lite_bridge.sv
hdl/multicore_wrapper.sv
tb/tb_multicore_wrapper.sv

// ==== tb/tb_multicore_wrapper.sv ====
`timescale 1ns/10ps

module tb_multicore_wrapper;

    localparam int NUM_REQ = multicore_cfg_pkg::NUM_REQUESTERS;
    localparam int NUM_ROWS = 27;
    localparam int FIXED_ROWS = 7;
    // worst case of one access in cycles with ready delays of up to 3.
    localparam int ACCESS_CYCLES = 12;
    localparam int LIMIT_NS = NUM_ROWS * NUM_REQ * ACCESS_CYCLES * 4 + 8 * 4;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_t;

    logic CLK = 1'b0;
    logic rst_n;
    bus_types_pkg::addr_t [NUM_REQ-1:0] req_addr;
    bus_types_pkg::word_t [NUM_REQ-1:0] req_wdata;
    bus_types_pkg::strobe_t [NUM_REQ-1:0] req_byte_en;
    logic [NUM_REQ-1:0] req_ren;
    logic [NUM_REQ-1:0] req_wen;
    bus_types_pkg::word_t [NUM_REQ-1:0] req_rdata;
    logic [NUM_REQ-1:0] req_busy;
    bus_types_pkg::addr_t awaddr;
    bus_types_pkg::addr_t araddr;
    bus_types_pkg::word_t wdata_axi;
    bus_types_pkg::word_t rdata_axi;
    bus_types_pkg::strobe_t wstrb;
    bus_types_pkg::axi_resp_t bresp;
    bus_types_pkg::axi_resp_t rresp;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;

    // one row is one test; a set mask bit makes that requester take part.
    logic [NUM_REQ-1:0] tbl_mask [NUM_ROWS];
    op_t tbl_op [NUM_ROWS][NUM_REQ];
    bus_types_pkg::addr_t tbl_addr [NUM_ROWS][NUM_REQ];
    bus_types_pkg::word_t tbl_data [NUM_ROWS][NUM_REQ];
    bus_types_pkg::strobe_t tbl_strb [NUM_ROWS][NUM_REQ];

    bus_types_pkg::word_t ref_mem [bus_types_pkg::addr_t];
    bus_types_pkg::word_t axi_mem [bus_types_pkg::addr_t];
    int busy_low_cnt [NUM_REQ] = '{default: 0};
    int done_order [$];
    int last_served = NUM_REQ - 1;
    int errors = 0;
    int checks = 0;

    multicore_wrapper dut0 (.*);

    always #2 CLK = ~CLK;

    // unwritten words read back a pattern made from the whole address.
    function automatic bus_types_pkg::word_t fill_word(input bus_types_pkg::addr_t a);
        return a ^ 32'h9e37_79b9;
    endfunction

    function automatic bus_types_pkg::word_t merge_bytes(input bus_types_pkg::word_t old,
            input bus_types_pkg::word_t data, input bus_types_pkg::strobe_t strb);
        bus_types_pkg::word_t res;
        res = old;
        for (int b = 0; b < bus_types_pkg::STROBE_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic bus_types_pkg::word_t ref_word(input bus_types_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic set_op(input int row, input int r, input op_t op,
            input bus_types_pkg::addr_t a, input bus_types_pkg::word_t d,
            input bus_types_pkg::strobe_t s);
        tbl_mask[row][r] = 1'b1;
        tbl_op[row][r] = op;
        tbl_addr[row][r] = a;
        tbl_data[row][r] = d;
        tbl_strb[row][r] = s;
    endtask

    task automatic build_table();
        tbl_mask = '{default: '0};
        set_op(0, 0, OP_WRITE, 32'h100, 32'hdead_beef, 4'hf);
        set_op(1, 0, OP_READ, 32'h100, 32'h0, 4'hf);
        // partial writes merge into a written word and into the fill pattern.
        set_op(2, 1, OP_WRITE, 32'h104, 32'h5566_7788, 4'h6);
        set_op(2, 3, OP_WRITE, 32'h100, 32'h1122_3344, 4'h5);
        set_op(3, 1, OP_READ, 32'h104, 32'h0, 4'hf);
        set_op(3, 3, OP_READ, 32'h100, 32'h0, 4'hf);
        // last grant is 3 here, so all four start together and finish 0 to 3.
        for (int r = 0; r < NUM_REQ; r++) begin
            set_op(4, r, OP_WRITE, 32'h200 + 4 * r, 32'h0a0b_0c00 + r, 4'hf);
            set_op(5, r, OP_READ, 32'h200 + 4 * (NUM_REQ - 1 - r), 32'h0, 4'hf);
        end
        set_op(6, 0, OP_READ, 32'h104, 32'h0, 4'hf);
        set_op(6, 1, OP_WRITE, 32'h208, 32'hcafe_f00d, 4'hc);
        set_op(6, 2, OP_READ, 32'h208, 32'h0, 4'hf);
        for (int row = FIXED_ROWS; row < NUM_ROWS; row++) begin
            for (int r = 0; r < NUM_REQ; r++) begin
                // a small address pool makes reads hit recent writes.
                if ($urandom_range(3, 0) != 0) begin
                    set_op(row, r, op_t'($urandom_range(1, 0)),
                           32'h1000 + ($urandom_range(7, 0) << 2), $urandom(),
                           bus_types_pkg::strobe_t'($urandom_range(15, 1)));
                end
            end
        end
    endtask

    task automatic run_requester(input int row, input int r);
        if (tbl_mask[row][r]) begin
            req_addr[r] = tbl_addr[row][r];
            req_wdata[r] = tbl_data[row][r];
            req_byte_en[r] = tbl_strb[row][r];
            req_ren[r] = (tbl_op[row][r] == OP_READ);
            req_wen[r] = (tbl_op[row][r] == OP_WRITE);
            do begin
                @(negedge CLK);
            end while (req_busy[r]);
            if (tbl_op[row][r] == OP_READ) begin
                check_value($sformatf("req_rdata[%0d]", r), ref_word(tbl_addr[row][r]),
                            req_rdata[r]);
            end else begin
                ref_mem[tbl_addr[row][r]] = merge_bytes(ref_word(tbl_addr[row][r]),
                                                        tbl_data[row][r], tbl_strb[row][r]);
            end
            done_order.push_back(r);
            @(posedge CLK);
            #1;
            req_ren[r] = 1'b0;
            req_wen[r] = 1'b0;
        end
    endtask

    // expected order is the round-robin walk that starts above the last grant.
    task automatic check_round_robin(input int row);
        int expected_order [$];
        int idx;
        for (int k = 1; k <= NUM_REQ; k++) begin
            idx = (last_served + k) % NUM_REQ;
            if (tbl_mask[row][idx]) begin
                expected_order.push_back(idx);
            end
        end
        for (int i = 0; i < expected_order.size() && i < done_order.size(); i++) begin
            check_value($sformatf("completion_order[%0d]", i), expected_order[i], done_order[i]);
        end
        if (expected_order.size() > 0) begin
            last_served = expected_order[$];
        end
    endtask

    task automatic serve_write();
        int aw_wait;
        int w_wait;
        bit aw_got;
        bit w_got;
        bus_types_pkg::addr_t a;
        bus_types_pkg::word_t d;
        bus_types_pkg::strobe_t s;
        aw_wait = $urandom_range(3, 0);
        w_wait = $urandom_range(3, 0);
        aw_got = 1'b0;
        w_got = 1'b0;
        // aw and w are accepted on their own delays.
        while (!(aw_got && w_got)) begin
            @(posedge CLK);
            #1;
            awready = !aw_got && (aw_wait == 0);
            wready = !w_got && (w_wait == 0);
            aw_wait = (aw_wait > 0) ? aw_wait - 1 : 0;
            w_wait = (w_wait > 0) ? w_wait - 1 : 0;
            @(negedge CLK);
            if (awvalid && awready) begin
                a = awaddr;
                aw_got = 1'b1;
            end
            if (wvalid && wready) begin
                d = wdata_axi;
                s = wstrb;
                w_got = 1'b1;
            end
        end
        @(posedge CLK);
        #1;
        awready = 1'b0;
        wready = 1'b0;
        axi_mem[a] = merge_bytes(axi_mem.exists(a) ? axi_mem[a] : fill_word(a), d, s);
        repeat ($urandom_range(3, 0)) begin
            @(posedge CLK);
            #1;
        end
        bresp = '0;
        bvalid = 1'b1;
        do begin
            @(negedge CLK);
        end while (!bready);
        @(posedge CLK);
        #1;
        bvalid = 1'b0;
    endtask

    task automatic serve_read();
        bus_types_pkg::addr_t a;
        repeat ($urandom_range(3, 0) + 1) begin
            @(posedge CLK);
            #1;
        end
        arready = 1'b1;
        @(negedge CLK);
        a = araddr;
        @(posedge CLK);
        #1;
        arready = 1'b0;
        repeat ($urandom_range(3, 0)) begin
            @(posedge CLK);
            #1;
        end
        rdata_axi = axi_mem.exists(a) ? axi_mem[a] : fill_word(a);
        rresp = '0;
        rvalid = 1'b1;
        do begin
            @(negedge CLK);
        end while (!rready);
        @(posedge CLK);
        #1;
        rvalid = 1'b0;
    endtask

    initial begin : axi_memory_model
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata_axi = '0;
        rresp = '0;
        forever begin
            @(negedge CLK);
            if (awvalid || wvalid) begin
                serve_write();
            end else if (arvalid) begin
                serve_read();
            end
        end
    end

    always @(negedge CLK) begin
        if (rst_n) begin
            for (int r = 0; r < NUM_REQ; r++) begin
                if (!req_busy[r]) begin
                    busy_low_cnt[r]++;
                end
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: accesses still pending after %0d ns", LIMIT_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        int errors_before;
        int cnt_before [NUM_REQ];
        void'($urandom(32'h7f31_2901));
        rst_n = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_byte_en = '0;
        req_ren = '0;
        req_wen = '0;
        build_table();
        repeat (8) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        @(negedge CLK);
        check_value("req_busy", (1 << NUM_REQ) - 1, 32'(req_busy));
        check_value("awvalid", 0, 32'(awvalid));
        check_value("wvalid", 0, 32'(wvalid));
        check_value("arvalid", 0, 32'(arvalid));
        check_value("bready", 0, 32'(bready));
        check_value("rready", 0, 32'(rready));
        $display("reset test: %0d errors", errors);
        for (int row = 0; row < NUM_ROWS; row++) begin
            errors_before = errors;
            cnt_before = busy_low_cnt;
            done_order.delete();
            @(posedge CLK);
            #1;
            // one branch per requester, all starting in the same cycle.
            fork
                run_requester(row, 0);
                run_requester(row, 1);
                run_requester(row, 2);
                run_requester(row, 3);
            join
            repeat (2) @(posedge CLK);
            #1;
            check_round_robin(row);
            for (int r = 0; r < NUM_REQ; r++) begin
                check_value($sformatf("busy_low_count[%0d]", r), 32'(tbl_mask[row][r]),
                            busy_low_cnt[r] - cnt_before[r]);
            end
            $display("test %0d: %0d requests, %0d errors", row, $countones(tbl_mask[row]),
                     errors - errors_before);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", NUM_ROWS + 1, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
